/* hw/cache_pkg.sv */
/*
 Shared definitions for the two-line data cache subsystem.
 Holds the cache and line store geometry, the controller state
 encoding and the packed structs passed between the blocks.
*/
package cache_pkg;

	localparam int WORD_BITS = 32;
	localparam int LINE_BITS = 128;		// Four 32-bit words.
	localparam int LINE_WORDS = LINE_BITS / WORD_BITS;
	localparam int PAGE_BITS = 28;		// Byte address without its low 4 bits.

	localparam int STORE_LINES = 64;	// 1 KiB of backing memory.
	localparam int STORE_INDEX_BITS = $clog2(STORE_LINES);
	localparam int STORE_LATENCY = 4;
	localparam int STORE_COUNT_BITS = $clog2(STORE_LATENCY);

	typedef enum logic [3:0] {
		st_idle,
		st_write_back_0,
		st_write_back_1,
		st_read_line_0,
		st_read_line_1,
		st_process_0,
		st_process_1,
		st_wait_end
	} cache_state_t;

	typedef struct packed {
		logic [PAGE_BITS-1:0] page;
		logic [LINE_BITS-1:0] data;
		logic valid;
		logic dirty;
	} cache_line_t;

	typedef struct packed {
		logic rw;				// 1 = write.
		logic [31:0] address;	// Byte address.
		logic [WORD_BITS-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic request;
		logic rw;
		logic [31:0] address;	// Line aligned.
		logic [LINE_BITS-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] hits;
		logic [31:0] misses;
	} cache_stats_t;

endpackage

/* hw/line_cache.sv */
/*
 Two-line write-back data cache controller.
 A CPU word request is checked against both tagged lines. On a miss the
 slot named by the channel input is refilled from the line store, after a
 dirty victim has been written back. One word is then read or updated.
*/
`timescale 1ns/1ps

module line_cache import cache_pkg::*; (
	input  logic                 i_clock,
	input  logic                 i_rst,
	input  logic                 i_request,
	input  cpu_req_t             i_cpu,
	input  logic                 i_channel,	// Victim slot on a miss.
	output logic [WORD_BITS-1:0] o_rdata,
	output logic                 o_ready,
	output mem_req_t             o_mem,
	input  logic [LINE_BITS-1:0] i_mem_rdata,
	input  logic                 i_mem_ready,
	output logic                 o_hit_event,
	output logic                 o_miss_event
);

	cache_state_t state;
	cache_line_t slot [2];

	logic ready_q;
	logic sel;
	logic hit_0;
	logic hit_1;
	logic mem_done;
	logic [PAGE_BITS-1:0] in_page;
	logic [1:0] in_word;
	logic [6:0] word_base;

	assign in_page = i_cpu.address[31:4];
	assign in_word = i_cpu.address[3:2];
	assign word_base = {in_word, 5'd0};	// Bit offset of the word in a line.

	assign hit_0 = slot[0].valid && (slot[0].page == in_page);
	assign hit_1 = slot[1].valid && (slot[1].page == in_page);

	assign mem_done = o_mem.request && i_mem_ready;

	// Falls in the same cycle the CPU drops its request.
	assign o_ready = ready_q && i_request;

	// Slot worked on by the current state.
	always_comb begin
		case (state)
			st_write_back_1,
			st_read_line_1,
			st_process_1: sel = 1'b1;
			default: sel = 1'b0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		o_hit_event <= 1'b0;
		o_miss_event <= 1'b0;
		if (i_rst) begin
			state <= st_idle;
			ready_q <= 1'b0;
			o_mem.request <= 1'b0;
			slot[0].valid <= 1'b0;
			slot[0].dirty <= 1'b0;
			slot[1].valid <= 1'b0;
			slot[1].dirty <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (i_request) begin
						if (hit_0) begin
							o_hit_event <= 1'b1;
							state <= st_process_0;
						end else if (hit_1) begin
							o_hit_event <= 1'b1;
							state <= st_process_1;
						end else begin
							o_miss_event <= 1'b1;
							if (!i_channel) begin
								if (slot[0].valid && slot[0].dirty)
									state <= st_write_back_0;
								else
									state <= st_read_line_0;
							end else begin
								if (slot[1].valid && slot[1].dirty)
									state <= st_write_back_1;
								else
									state <= st_read_line_1;
							end
						end
					end
				end

				st_write_back_0,
				st_write_back_1: begin
					o_mem.request <= 1'b1;
					o_mem.rw <= 1'b1;
					o_mem.address <= {slot[sel].page, 4'b0000};
					o_mem.wdata <= slot[sel].data;
					if (mem_done) begin
						o_mem.request <= 1'b0;
						state <= sel ? st_read_line_1 : st_read_line_0;
					end
				end

				st_read_line_0,
				st_read_line_1: begin
					o_mem.request <= 1'b1;
					o_mem.rw <= 1'b0;
					o_mem.address <= {in_page, 4'b0000};
					if (mem_done) begin
						o_mem.request <= 1'b0;
						slot[sel].page <= in_page;
						slot[sel].data <= i_mem_rdata;
						slot[sel].valid <= 1'b1;
						slot[sel].dirty <= 1'b0;
						state <= sel ? st_process_1 : st_process_0;
					end
				end

				st_process_0,
				st_process_1: begin
					if (i_cpu.rw) begin
						slot[sel].data[word_base +: WORD_BITS] <= i_cpu.wdata;
						slot[sel].dirty <= 1'b1;
					end else begin
						o_rdata <= slot[sel].data[word_base +: WORD_BITS];
					end
					state <= st_wait_end;
				end

				// Hold ready until the CPU lets go of the request.
				st_wait_end: begin
					ready_q <= i_request;
					if (!i_request)
						state <= st_idle;
				end

				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* hw/cache_stats.sv */
/*
 Cache status block.
 Counts hit and miss events from the cache controller and clears
 both counters on command.
*/
`timescale 1ns/1ps

module cache_stats import cache_pkg::*; (
	input  logic         i_clock,
	input  logic         i_rst,
	input  logic         i_stats_clear,
	input  logic         i_hit_event,
	input  logic         i_miss_event,
	output cache_stats_t o_stats
);

	logic [31:0] hits;
	logic [31:0] misses;

	always_ff @(posedge i_clock) begin
		if (i_rst || i_stats_clear) begin	// Clear wins over a same-cycle event.
			hits <= '0;
			misses <= '0;
		end else begin
			if (i_hit_event)
				hits <= hits + 32'd1;
			if (i_miss_event)
				misses <= misses + 32'd1;
		end
	end

	assign o_stats.hits = hits;
	assign o_stats.misses = misses;

endmodule

/* hw/line_store.sv */
/*
 On-chip backing memory of 128-bit lines.
 A held request is served after a fixed latency with a one-cycle
 ready pulse. Each word starts out holding its own byte address.
*/
`timescale 1ns/1ps

module line_store import cache_pkg::*; (
	input  logic                 i_clock,
	input  logic                 i_rst,
	input  mem_req_t             i_mem,
	output logic [LINE_BITS-1:0] o_rdata,
	output logic                 o_ready
);

	logic [LINE_BITS-1:0] mem [STORE_LINES];

	logic [STORE_INDEX_BITS-1:0] index;
	logic [STORE_COUNT_BITS-1:0] count;
	logic busy;
	logic done;		// Served, waiting for the request to drop.
	logic fire;

	assign index = i_mem.address[4 +: STORE_INDEX_BITS];
	assign fire = busy && (count == '0);

	initial begin
		for (int l = 0; l < STORE_LINES; l++) begin
			for (int w = 0; w < LINE_WORDS; w++) begin
				mem[l][w*WORD_BITS +: WORD_BITS] = WORD_BITS'(l * 16 + w * 4);
			end
		end
	end

	always_ff @(posedge i_clock) begin
		o_ready <= 1'b0;
		if (i_rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else if (busy) begin
			if (fire) begin
				busy <= 1'b0;
				done <= 1'b1;
				o_ready <= 1'b1;
			end else begin
				count <= count - 1'b1;
			end
		end else if (i_mem.request && !done) begin
			busy <= 1'b1;
			count <= STORE_COUNT_BITS'(STORE_LATENCY - 1);
		end else if (!i_mem.request) begin
			done <= 1'b0;
		end
	end

	// The access itself happens on the last cycle of the countdown.
	always_ff @(posedge i_clock) begin
		if (fire) begin
			if (i_mem.rw)
				mem[index] <= i_mem.wdata;
			else
				o_rdata <= mem[index];
		end
	end

endmodule

/* hw/cache_subsystem.sv */
/*
 Data cache subsystem top level.
 Connects the two-line cache controller to its on-chip line store
 and to the hit and miss status block.
*/
`timescale 1ns/1ps

module cache_subsystem import cache_pkg::*; (
	input  logic                 i_clock,
	input  logic                 i_rst,

	// CPU port.
	input  logic                 i_request,
	input  cpu_req_t             i_cpu,
	input  logic                 i_channel,
	output logic [WORD_BITS-1:0] o_rdata,
	output logic                 o_ready,

	// Status.
	input  logic                 i_stats_clear,
	output cache_stats_t         o_stats
);

	mem_req_t mem_req;
	logic [LINE_BITS-1:0] mem_rdata;
	logic mem_ready;
	logic hit_event;
	logic miss_event;

	line_cache u_cache (
		.i_clock      (i_clock),
		.i_rst        (i_rst),
		.i_request    (i_request),
		.i_cpu        (i_cpu),
		.i_channel    (i_channel),
		.o_rdata      (o_rdata),
		.o_ready      (o_ready),
		.o_mem        (mem_req),
		.i_mem_rdata  (mem_rdata),
		.i_mem_ready  (mem_ready),
		.o_hit_event  (hit_event),
		.o_miss_event (miss_event)
	);

	cache_stats u_stats (
		.i_clock       (i_clock),
		.i_rst         (i_rst),
		.i_stats_clear (i_stats_clear),
		.i_hit_event   (hit_event),
		.i_miss_event  (miss_event),
		.o_stats       (o_stats)
	);

	line_store u_store (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_mem   (mem_req),
		.o_rdata (mem_rdata),
		.o_ready (mem_ready)
	);

endmodule

/* test/tb_clock.sv */
/*
 Testbench clock and reset generator.
 Makes a 100 ns clock and holds reset high for the first 16 cycles.
*/
`timescale 1ns/1ps

module tb_clock (
	output logic o_clock,
	output logic o_rst
);

	localparam int HALF_PERIOD_NS = 50;
	localparam int RESET_CYCLES = 16;

	initial begin
		o_clock = 1'b0;
		forever #(HALF_PERIOD_NS) o_clock = ~o_clock;
	end

	initial begin
		o_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_rst <= 1'b0;	// Released on a rising edge.
	end

endmodule

/* test/tb_cache.sv */
/*
 Testbench for the two-line data cache subsystem.
 Drives CPU reads and writes, keeps its own model of the memory image
 and of both cache slots, and checks data, hit timing and the counters.
*/
`timescale 1ns/1ps

module tb_cache import cache_pkg::*; ();

	localparam logic [31:0] SEED = 32'h2420ab2e;
	localparam int HIT_EDGES = 4;	// Drive, sample, process, wait end.
	localparam int FILL_EDGES = STORE_LATENCY + 1;
	localparam int READY_TIMEOUT = 200;
	localparam int RESET_TIMEOUT = 100;
	localparam int RANDOM_OPS = 400;
	localparam int MODEL_WORDS = 256;	// 1 KiB of words.

	logic clock;
	logic rst;
	logic request;
	cpu_req_t cpu_req;
	logic channel;
	logic [WORD_BITS-1:0] rdata;
	logic ready;
	logic stats_clear;
	cache_stats_t stats;

	// Model of what the CPU sees, and of the slot tags.
	logic [31:0] view_mem [MODEL_WORDS];
	logic [PAGE_BITS-1:0] model_page [2];
	logic model_valid [2];
	logic model_dirty [2];
	logic [31:0] model_hits;
	logic [31:0] model_misses;

	tb_clock u_clock (
		.o_clock (clock),
		.o_rst   (rst)
	);

	cache_subsystem uut (
		.i_clock       (clock),
		.i_rst         (rst),
		.i_request     (request),
		.i_cpu         (cpu_req),
		.i_channel     (channel),
		.o_rdata       (rdata),
		.o_ready       (ready),
		.i_stats_clear (stats_clear),
		.o_stats       (stats)
	);

	task automatic require(input bit cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic compare_hex(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		require(got === exp, $sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	task automatic verify_counts();
		compare_hex("o_stats.hits", stats.hits, model_hits);
		compare_hex("o_stats.misses", stats.misses, model_misses);
	endtask

	task automatic init_model();
		for (int w = 0; w < MODEL_WORDS; w++)
			view_mem[w] = 32'(w * 4);	// Each word holds its byte address.
		for (int s = 0; s < 2; s++) begin
			model_valid[s] = 1'b0;
			model_dirty[s] = 1'b0;
			model_page[s] = '0;
		end
		model_hits = '0;
		model_misses = '0;
	endtask

	// One CPU access with the expected result worked out from the model first.
	task automatic cpu_access(input logic rw, input logic [31:0] addr,
			input logic [31:0] wdata, input logic chan);
		cpu_req_t req;
		logic [PAGE_BITS-1:0] page;
		logic hit;
		logic victim_dirty;
		int slot;
		int edges;
		int min_edges;
		logic [31:0] expect_data;

		page = addr[31:4];
		hit = 1'b0;
		slot = 0;
		victim_dirty = 1'b0;
		for (int s = 0; s < 2; s++) begin
			if (model_valid[s] && model_page[s] == page) begin
				hit = 1'b1;
				slot = s;
			end
		end
		if (hit) begin
			model_hits = model_hits + 32'd1;
		end else begin
			slot = int'(chan);
			victim_dirty = model_valid[slot] && model_dirty[slot];
			model_page[slot] = page;
			model_valid[slot] = 1'b1;
			model_dirty[slot] = 1'b0;
			model_misses = model_misses + 32'd1;
		end
		if (rw) begin
			model_dirty[slot] = 1'b1;
			view_mem[addr[9:2]] = wdata;
		end
		expect_data = view_mem[addr[9:2]];
		min_edges = HIT_EDGES + FILL_EDGES;
		if (victim_dirty)
			min_edges = HIT_EDGES + 2 * FILL_EDGES;	// Write-back, then fill.

		req.rw = rw;
		req.address = addr;
		req.wdata = wdata;
		@(posedge clock);
		request <= 1'b1;
		cpu_req <= req;
		channel <= chan;

		edges = 0;
		while (ready !== 1'b1 && edges < READY_TIMEOUT) begin
			@(negedge clock);
			edges++;
		end
		require(ready === 1'b1, "Timeout: o_ready did not rise for a CPU request");
		if (hit)
			compare_hex("o_ready latency", 32'(edges), 32'(HIT_EDGES));
		else
			require(edges >= min_edges, "A miss completed faster than its line transfers allow");
		if (!rw)
			compare_hex("o_rdata", rdata, expect_data);

		@(posedge clock);
		request <= 1'b0;
		@(negedge clock);
		compare_hex("o_ready after request drop", 32'(ready), 32'h0);
		verify_counts();
	endtask

	task automatic clear_counters();
		@(posedge clock);
		stats_clear <= 1'b1;
		@(posedge clock);
		stats_clear <= 1'b0;
		@(negedge clock);
		model_hits = '0;
		model_misses = '0;
		verify_counts();
	endtask

	task automatic random_traffic();
		logic [31:0] rnd;
		logic [31:0] addr;

		repeat (RANDOM_OPS) begin
			rnd = $urandom();
			if (rnd[5:4] == 2'b00)
				addr = {22'd0, rnd[17:10], 2'b00};	// Anywhere in the store.
			else
				addr = {26'd0, rnd[13:10], 2'b00};	// Only four lines so that hits are common.
			cpu_access(rnd[1], addr, $urandom(), rnd[2]);
		end
	endtask

	initial begin
		int cycles;

		request = 1'b0;
		cpu_req = '0;
		channel = 1'b0;
		stats_clear = 1'b0;
		void'($urandom(SEED));
		init_model();

		cycles = 0;
		while (rst !== 1'b0 && cycles < RESET_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		require(rst === 1'b0, "Timeout: reset was never released");
		compare_hex("o_ready after reset", 32'(ready), 32'h0);
		compare_hex("mem_req.request after reset", 32'(uut.mem_req.request), 32'h0);
		verify_counts();

		cpu_access(1'b0, 32'h0000_0100, 32'h0, 1'b0);	// Clean miss and fill.

		cpu_access(1'b1, 32'h0000_0104, 32'hdead_beef, 1'b0);
		cpu_access(1'b0, 32'h0000_0104, 32'h0, 1'b0);	// Read back as a hit.

		// Both accesses on channel 0 push a dirty line out to the store.
		cpu_access(1'b1, 32'h0000_0240, 32'h1234_5678, 1'b0);
		cpu_access(1'b0, 32'h0000_0380, 32'h0, 1'b0);
		cpu_access(1'b0, 32'h0000_0240, 32'h0, 1'b1);

		cpu_access(1'b0, 32'h0000_0244, 32'h0, 1'b0);	// Resident line, hit timing.

		clear_counters();
		cpu_access(1'b0, 32'h0000_0380, 32'h0, 1'b1);
		cpu_access(1'b0, 32'h0000_0000, 32'h0, 1'b0);

		random_traffic();
		verify_counts();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* list.f */
hw/cache_pkg.sv
hw/line_cache.sv
hw/cache_stats.sv
hw/line_store.sv
hw/cache_subsystem.sv
test/tb_clock.sv
test/tb_cache.sv

/* run.sh */
#!/bin/sh
# Build the cache testbench with Verilator, run it and judge the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cache -f list.f

# The pipe returns the status of tee, so the log decides the result.
./obj_dir/Vtb_cache 2>&1 | tee sim.log

if grep -q -F '*** FAILED ***' sim.log; then
	echo "Simulation failed."
	exit 1
fi
if ! grep -q -F '*** PASSED ***' sim.log; then
	echo "Simulation ended without a result."
	exit 1
fi
echo "Simulation passed."
